// File: logic/gamma_cfg_pkg.sv
// gamma configuration definitions
// register map, mode word and table entry/write port layouts
`default_nettype none

package gamma_cfg_pkg;

    typedef enum logic [1:0] {
        REG_CTRL      = 2'd0,                   // mode word, soft trigger
        REG_ADDR_DATA = 2'd1                    // table address or table data
    } gamma_reg_e;

    typedef struct packed {
        logic       trig;                       // soft trigger, pulse only
        logic       repet;                      // pass every frame
        logic       en;                         // block enable
        logic       unused;
        logic [1:0] bayer;                      // colour of first pixel
    } gamma_mode_t;

    // diff[7] selects scaled format, diff[6:0] value
    typedef struct packed {
        logic [7:0] diff;
        logic [9:0] base;                       // 2 bits more than output
    } table_word_t;

    localparam int TABLE_ADDR_W  = 10;          // {color, pixel high byte}
    localparam int ADDR_FLAG_BIT = 20;          // set: address write

    typedef struct packed {
        logic                    we;
        logic [TABLE_ADDR_W-1:0] addr;
        table_word_t             data;
    } table_wr_t;

endpackage

`default_nettype wire

// File: logic/gamma_pix_pkg.sv
// gamma pixel stream definitions
// input and output pixel buses, pipeline latency
`default_nettype none

package gamma_pix_pkg;

    typedef struct packed {
        logic        hact;                      // line active
        logic        sof;                       // start of frame, one cycle
        logic        eof;                       // end of frame
        logic [15:0] data;                      // raw sensor pixel
    } pix_in_t;

    typedef struct packed {
        logic       hact;
        logic       sof;                        // gated sof
        logic       eof;
        logic [7:0] data;                       // gamma corrected pixel
    } pix_out_t;

    // input to output latency in clock cycles
    localparam int PIPE_DEPTH = 5;

endpackage

`default_nettype wire

// File: logic/gamma_regs.sv
// gamma register block
// decodes parallel writes into mode, table address counter and table writes
`timescale 1ns/1ps
`default_nettype none

module gamma_regs
    import gamma_cfg_pkg::*;
(
    input  logic        rst,                    // clock
    input  logic        mclk,                   // async reset, active high
    input  logic        cmd_we,                 // one-cycle write strobe
    input  gamma_reg_e  cmd_addr,
    input  logic [31:0] cmd_data,
    output gamma_mode_t mode,
    output table_wr_t   table_wr,
    output logic        soft_trig               // one-cycle pulse
);

    logic                    set_ctrl;
    logic                    set_taddr;
    logic                    set_tdata;
    logic [TABLE_ADDR_W-1:0] taddr;             // auto-incrementing table pointer
    gamma_mode_t             mode_raw;
    gamma_mode_t             mode_nxt;
    logic                    wr_we;
    logic [TABLE_ADDR_W-1:0] wr_addr;
    table_word_t             wr_data;

    assign set_ctrl  = cmd_we && (cmd_addr == REG_CTRL);
    assign set_taddr = cmd_we && (cmd_addr == REG_ADDR_DATA) && cmd_data[ADDR_FLAG_BIT];
    assign set_tdata = cmd_we && (cmd_addr == REG_ADDR_DATA) && !cmd_data[ADDR_FLAG_BIT];

    always_comb begin
        mode_raw      = gamma_mode_t'(cmd_data[$bits(gamma_mode_t)-1:0]);
        mode_nxt      = mode_raw;
        mode_nxt.trig = 1'b0;                   // trig is never held
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            mode      <= '0;
            taddr     <= '0;
            wr_we     <= 1'b0;
            soft_trig <= 1'b0;
        end else begin
            if (set_ctrl) mode <= mode_nxt;
            if (set_taddr) taddr <= cmd_data[TABLE_ADDR_W-1:0];
            else if (set_tdata) taddr <= taddr + TABLE_ADDR_W'(1); // next entry
            wr_we     <= set_tdata;
            soft_trig <= set_ctrl && mode_raw.trig;
        end
    end

    // write address and data, sampled with the strobe
    always_ff @(posedge rst) begin
        if (set_tdata) begin
            wr_addr <= taddr;
            wr_data <= table_word_t'(cmd_data[$bits(table_word_t)-1:0]);
        end
    end

    assign table_wr = '{we: wr_we, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// File: logic/gamma_table_ram.sv
// gamma table memory
// simple dual port, write from registers, 2-cycle registered read
`timescale 1ns/1ps
`default_nettype none

module gamma_table_ram
    import gamma_cfg_pkg::*;
#(
    parameter int ADDR_W = TABLE_ADDR_W,        // {color, high byte}
    parameter int DATA_W = $bits(table_word_t)
) (
    input  logic              rst,              // clock
    input  table_wr_t         table_wr,
    input  logic [ADDR_W-1:0] raddr,
    input  logic              re,
    output table_word_t       rdata
);

    logic [DATA_W-1:0] mem [2**ADDR_W];         // 4 pages of 256 words
    logic [DATA_W-1:0] rd_q;                    // array read register
    logic              re_q;                    // output register enable

    always_ff @(posedge rst) begin
        if (table_wr.we) mem[table_wr.addr] <= table_wr.data;
        if (re) rd_q <= mem[raddr];
        re_q <= re;
        if (re_q) rdata <= rd_q;                // valid 2 cycles after raddr
    end

endmodule

`default_nettype wire

// File: logic/gamma_frame_gate.sv
// frame gate
// passes sof only when enabled and in repeat mode or with a pending trigger
`timescale 1ns/1ps
`default_nettype none

module gamma_frame_gate
    import gamma_cfg_pkg::*;
    import gamma_pix_pkg::*;
(
    input  logic        rst,                    // clock
    input  logic        mclk,                   // async reset, active high
    input  pix_in_t     pix,
    input  gamma_mode_t mode,
    input  logic        trig_in,                // external trigger pulse
    input  logic        soft_trig,              // trigger from control write
    output logic        sof_pass,
    output logic        frame_run               // sof_pass until eof
);

    logic trig;
    logic vblank;                               // from sof to first hact
    logic pend_trig;                            // trigger waiting for next sof

    assign trig = trig_in || soft_trig;

    // combinational, same cycle as the input sof
    assign sof_pass = pix.sof && mode.en && (pend_trig || mode.repet);

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            vblank    <= 1'b0;
            pend_trig <= 1'b0;
            frame_run <= 1'b0;
        end else begin
            vblank    <= pix.sof || (vblank && !pix.hact);
            // trigger inside vblank is too late for this frame, dropped
            pend_trig <= (trig && !vblank) || (pend_trig && !pix.sof);
            frame_run <= sof_pass || (frame_run && !pix.eof);
        end
    end

endmodule

`default_nettype wire

// File: logic/bayer_color_tracker.sv
// bayer colour tracker
// gives the colour of the current pixel, used as the table page
`timescale 1ns/1ps
`default_nettype none

module bayer_color_tracker
    import gamma_cfg_pkg::*;
(
    input  logic        rst,                    // clock
    input  logic        mclk,                   // async reset, active high
    input  logic        hact,
    input  logic        frame_run,
    input  gamma_mode_t mode,
    output logic [1:0]  color
);

    logic       in_run;                         // first hact of the run seen
    logic       hact_q;
    logic [1:0] color_q;                        // colour of previous pixel
    logic       b0_lat;                         // bayer[0] at start of run

    always_comb begin
        if (!in_run || !frame_run) color = mode.bayer; // outside a run or first pixel
        else if (hact && hact_q) color = {color_q[1], ~color_q[0]};
        else if (hact) color = {~color_q[1], b0_lat}; // new line
        else color = color_q;                   // hold between lines
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            in_run  <= 1'b0;
            hact_q  <= 1'b0;
            color_q <= '0;
            b0_lat  <= 1'b0;
        end else begin
            in_run  <= frame_run && (in_run || hact);
            hact_q  <= hact;
            color_q <= color;
            if (!in_run) b0_lat <= mode.bayer[0];
        end
    end

endmodule

`default_nettype wire

// File: logic/gamma_interp.sv
// gamma interpolator
// table lookup, piecewise-linear interpolation and 5-cycle sync alignment
`timescale 1ns/1ps
`default_nettype none

module gamma_interp
    import gamma_cfg_pkg::*;
    import gamma_pix_pkg::*;
(
    input  logic                    rst,        // clock
    input  logic                    mclk,       // async reset, active high
    input  pix_in_t                 pix,
    input  logic                    sof_pass,   // gated sof, replaces pix.sof
    input  logic [1:0]              color,
    input  table_word_t             rdata,      // 2 cycles after raddr
    output logic [TABLE_ADDR_W-1:0] raddr,
    output logic                    re,
    output pix_out_t                pix_out
);

    typedef struct packed {
        logic hact;
        logic sof;
        logic eof;
    } sync_t;

    logic [2:0][7:0]             lo_d;          // pixel low byte delay
    logic signed [10:0]          diff_q;        // decoded difference
    logic [9:0]                  base_q;
    logic [9:0]                  base_q2;
    logic signed [19:0]          prod;
    logic [10:0]                 mult_q;        // prod[17:7], lsb for rounding
    logic [9:0]                  sum;
    logic [7:0]                  data_q;
    sync_t [PIPE_DEPTH-1:0]      sync_d;

    // stage 1, page from colour, entry from high byte
    assign raddr = {color, pix.data[15:8]};
    assign re    = pix.hact;

    assign prod = diff_q * $signed({1'b0, lo_d[2]}); // signed x positive
    assign sum  = base_q2 + mult_q[10:1] + {9'd0, mult_q[0]}; // half up, wraps

    always_ff @(posedge rst) begin
        lo_d    <= {lo_d[1:0], pix.data[7:0]};
        // stage 3 decode, scaled or sign-extended
        diff_q  <= rdata.diff[7] ? {rdata.diff[6:0], 4'b0000}
                                 : {{4{rdata.diff[6]}}, rdata.diff[6:0]};
        base_q  <= rdata.base;
        // stage 4 multiply
        mult_q  <= prod[17:7];
        base_q2 <= base_q;
    end

    // stage 5 output register and sync delay line
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            data_q <= '0;
            sync_d <= '0;
        end else begin
            data_q <= sum[9:2];                 // drop 2 extra bits
            sync_d <= {sync_d[PIPE_DEPTH-2:0], sync_t'{pix.hact, sof_pass, pix.eof}};
        end
    end

    assign pix_out = '{hact: sync_d[PIPE_DEPTH-1].hact,
                       sof:  sync_d[PIPE_DEPTH-1].sof,
                       eof:  sync_d[PIPE_DEPTH-1].eof,
                       data: data_q};

endmodule

`default_nettype wire

// File: logic/sens_gamma_top.sv
// sensor gamma top level
// 16 to 8 bit table based conversion with frame gating and bayer pages
`timescale 1ns/1ps
`default_nettype none

module sens_gamma_top
    import gamma_cfg_pkg::*;
    import gamma_pix_pkg::*;
#(
    parameter int TABLE_ADDR_W = gamma_cfg_pkg::TABLE_ADDR_W,
    parameter int TABLE_DATA_W = $bits(table_word_t)
) (
    input  logic        rst,                    // clock
    input  logic        mclk,                   // async reset, active high
    input  logic        cmd_we,
    input  gamma_reg_e  cmd_addr,
    input  logic [31:0] cmd_data,
    input  logic        trig_in,
    input  pix_in_t     pix_in,
    output pix_out_t    pix_out
);

    gamma_mode_t             mode;
    table_wr_t               table_wr;
    logic                    soft_trig;
    logic                    sof_pass;
    logic                    frame_run;
    logic [1:0]              color;             // current table page
    logic [TABLE_ADDR_W-1:0] raddr;
    logic                    re;
    table_word_t             rdata;

    gamma_regs u_regs (
        .rst       (rst),
        .mclk      (mclk),
        .cmd_we    (cmd_we),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .mode      (mode),
        .table_wr  (table_wr),
        .soft_trig (soft_trig)
    );

    gamma_table_ram #(
        .ADDR_W (TABLE_ADDR_W),
        .DATA_W (TABLE_DATA_W)
    ) u_table (
        .rst      (rst),
        .table_wr (table_wr),
        .raddr    (raddr),
        .re       (re),
        .rdata    (rdata)
    );

    gamma_frame_gate u_gate (
        .rst       (rst),
        .mclk      (mclk),
        .pix       (pix_in),
        .mode      (mode),
        .trig_in   (trig_in),
        .soft_trig (soft_trig),
        .sof_pass  (sof_pass),
        .frame_run (frame_run)
    );

    bayer_color_tracker u_color (
        .rst       (rst),
        .mclk      (mclk),
        .hact      (pix_in.hact),
        .frame_run (frame_run),
        .mode      (mode),
        .color     (color)
    );

    gamma_interp u_interp (
        .rst      (rst),
        .mclk     (mclk),
        .pix      (pix_in),
        .sof_pass (sof_pass),
        .color    (color),
        .rdata    (rdata),
        .raddr    (raddr),
        .re       (re),
        .pix_out  (pix_out)
    );

endmodule

`default_nettype wire

// File: verif/tb_clkgen.sv
// testbench clock and reset source
// free-running clock, reset held for a fixed number of cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic rst,                           // clock
    output logic mclk                           // reset, active high
);

    initial begin
        rst = 1'b0;
        forever #(PERIOD_NS / 2) rst = ~rst;
    end

    initial begin
        mclk = 1'b1;
        repeat (RESET_CYCLES) @(posedge rst);
        #2 mclk = 1'b0;                         // release off the edge
    end

endmodule

`default_nettype wire

// File: verif/sens_gamma_chk.sv
// gamma block checker
// concurrent assertions on reset, output sync and table write strobes
`timescale 1ns/1ps
`default_nettype none

module sens_gamma_chk
    import gamma_cfg_pkg::*;
    import gamma_pix_pkg::*;
(
    input logic      rst,                       // clock
    input logic      mclk,                      // async reset
    input logic      cmd_we,
    input pix_out_t  pix_out,
    input table_wr_t table_wr
);

    int unsigned fail_cnt = 0;                  // failed assertions so far

    // no active line while held in reset
    hact_in_reset: assert property (@(posedge rst) mclk |-> !pix_out.hact)
        else begin
            $error("pix_out.hact high during reset");
            fail_cnt++;
        end

    // sof sits in blanking, never on a pixel
    sof_with_hact: assert property (@(posedge rst) disable iff (mclk)
        !(pix_out.sof && pix_out.hact))
        else begin
            $error("pix_out.sof coincides with pix_out.hact");
            fail_cnt++;
        end

    // back-to-back table writes, one strobe each, consecutive entries
    b2b_table_write: assert property (@(posedge rst) disable iff (mclk)
        (table_wr.we && $past(table_wr.we)) |->
            ($past(cmd_we) && $past(cmd_we, 2) &&
             (table_wr.addr == $past(table_wr.addr) + 1'b1)))
        else begin
            $error("table_wr.we held without cmd_we or address step");
            fail_cnt++;
        end

endmodule

bind sens_gamma_top sens_gamma_chk chk_i (
    .rst      (rst),
    .mclk     (mclk),
    .cmd_we   (cmd_we),
    .pix_out  (pix_out),
    .table_wr (table_wr)
);

`default_nettype wire

// File: verif/sens_gamma_tb.sv
// gamma block testbench
// trace driven writes, triggers and pixels, outputs checked PIPE_DEPTH cycles later
`timescale 1ns/1ps
`default_nettype none

module sens_gamma_tb
    import gamma_cfg_pkg::*;
    import gamma_pix_pkg::*;
();

    localparam string TRACE_FILE    = "verif/gamma_trace.txt";
    localparam int    DRIVE_DELAY   = 2;        // ns after rising edge
    localparam int    RESET_TIMEOUT = 20;       // cycles
    localparam int    DRAIN_TIMEOUT = 4 * PIPE_DEPTH;

    // expected output of one driven cycle
    typedef struct packed {
        logic       chk_data;                   // data only meaningful on hact
        logic       hact;
        logic       sof;
        logic       eof;
        logic [7:0] data;
    } exp_t;

    logic        rst;                           // clock
    logic        mclk;                          // reset
    logic        cmd_we;
    gamma_reg_e  cmd_addr;
    logic [31:0] cmd_data;
    logic        trig_in;
    pix_in_t     pix_in;
    pix_out_t    pix_out;

    exp_t  exp_q[$];                            // oldest entry due next
    string test_name;
    int    test_checks;
    int    test_errors;
    int    tests;
    int    checks;
    int    errors;

    tb_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(4)) clk_i (.rst(rst), .mclk(mclk));

    sens_gamma_top #(
        .TABLE_ADDR_W (TABLE_ADDR_W),
        .TABLE_DATA_W ($bits(table_word_t))
    ) dut_i (
        .rst      (rst),
        .mclk     (mclk),
        .cmd_we   (cmd_we),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .trig_in  (trig_in),
        .pix_in   (pix_in),
        .pix_out  (pix_out)
    );

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic check_out(input exp_t e);
        test_checks++;
        if (pix_out.hact !== e.hact) begin
            $display("[FAIL] pix_out.hact exp %h got %h at %0t", e.hact, pix_out.hact, $time);
            test_errors++;
        end
        if (pix_out.sof !== e.sof) begin
            $display("[FAIL] pix_out.sof exp %h got %h at %0t", e.sof, pix_out.sof, $time);
            test_errors++;
        end
        if (pix_out.eof !== e.eof) begin
            $display("[FAIL] pix_out.eof exp %h got %h at %0t", e.eof, pix_out.eof, $time);
            test_errors++;
        end
        if (e.chk_data && pix_out.data !== e.data) begin
            $display("[FAIL] pix_out.data exp %h got %h at %0t", e.data, pix_out.data, $time);
            test_errors++;
        end
    endtask

    // one clock cycle: check the due output, then drive new inputs
    task automatic step(input pix_in_t p, input logic trig, input logic we,
                        input gamma_reg_e a, input logic [31:0] d, input exp_t e);
        @(posedge rst);
        #DRIVE_DELAY;
        if (exp_q.size() == PIPE_DEPTH) check_out(exp_q.pop_front());
        pix_in   = p;
        trig_in  = trig;
        cmd_we   = we;
        cmd_addr = a;
        cmd_data = d;
        exp_q.push_back(e);
    endtask

    task automatic idle();
        step('0, 1'b0, 1'b0, REG_CTRL, '0, '0);
    endtask

    function automatic logic in_flight();
        foreach (exp_q[i]) begin
            if (exp_q[i] != '0) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic drain();
        int n;
        n = 0;
        while (in_flight() && n < DRAIN_TIMEOUT) begin
            idle();
            n++;
        end
        if (in_flight()) abort_run("timeout: expected outputs still pending after drain");
    endtask

    task automatic finish_test();
        if (test_name.len() > 0) begin
            drain();
            $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
            tests++;
            checks += test_checks;
            errors += test_errors;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          gap;
        string       line;
        logic [31:0] v_a;
        logic [31:0] v_d;
        logic [31:0] v_hact;
        logic [31:0] v_sof;
        logic [31:0] v_eof;
        logic [31:0] v_exp;
        logic [31:0] v_esof;
        pix_in_t     p;
        exp_t        e;
        pix_in   = '0;
        trig_in  = 1'b0;
        cmd_we   = 1'b0;
        cmd_addr = REG_CTRL;
        cmd_data = '0;
        tests    = 0;
        checks   = 0;
        errors   = 0;
        void'($urandom(32'hb64d_f384));

        // outputs must sit at zero for the whole reset
        test_name   = "reset";
        test_checks = 0;
        test_errors = 0;
        n = 0;
        #1;
        while (mclk !== 1'b0 && n < RESET_TIMEOUT) begin
            test_checks++;
            if (pix_out !== '0) begin
                $display("[FAIL] pix_out exp %h got %h at %0t", 11'h000, pix_out, $time);
                test_errors++;
            end
            @(posedge rst);
            #1;
            n++;
        end
        if (mclk !== 1'b0) abort_run("timeout: reset was never released");
        finish_test();

        test_name = "";
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) abort_run("cannot open the trace file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            gap  = 0;
            if (line.len() < 1 || line[0] == "#" || line[0] == "\n") continue;
            case (line[0])
                "S": begin                      // new test, close the previous one
                    finish_test();
                    test_name = line.substr(2, line.len() - 2);
                end
                "W": begin
                    if ($sscanf(line, "W %h %h", v_a, v_d) != 2)
                        abort_run({"bad write record: ", line});
                    step('0, 1'b0, 1'b1, gamma_reg_e'(v_a[1:0]), v_d, '0);
                    gap = 1;
                end
                "T": begin
                    step('0, 1'b1, 1'b0, REG_CTRL, '0, '0);
                    gap = 1;
                end
                "I": begin
                    idle();
                    gap = 1;
                end
                "P": begin
                    if ($sscanf(line, "P %h %h %h %h %h %h", v_hact, v_sof, v_eof, v_d,
                                v_exp, v_esof) != 6)
                        abort_run({"bad pixel record: ", line});
                    p = '{hact: v_hact[0], sof: v_sof[0], eof: v_eof[0], data: v_d[15:0]};
                    // hact and eof come out as they went in, sof as gated
                    e = '{chk_data: v_hact[0], hact: v_hact[0], sof: v_esof[0],
                          eof: v_eof[0], data: v_exp[7:0]};
                    step(p, 1'b0, 1'b0, REG_CTRL, '0, e);
                end
                default: abort_run({"unknown trace record: ", line});
            endcase
            if (gap != 0) begin
                gap = $urandom % 4;             // 0 to 3 idle cycles
                repeat (gap) idle();
            end
        end
        $fclose(fd);
        finish_test();
        errors += dut_i.chk_i.fail_cnt;         // failed bound assertions

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/gamma_trace.txt
# W addr data | P hact sof eof data exp_data exp_sof | T trigger | I idle | S test name
# all numbers hex, bit 20 of a write to addr 1 selects a table address write
S flat
W 1 00100000
W 1 00000004
W 1 000003FF
W 1 00000203
W 1 00000155
I
P 1 0 0 00AB 01 0
P 1 0 0 01CD FF 0
P 1 0 0 02EF 80 0
P 1 0 0 0300 55 0
S interp
W 1 00100010
W 1 00008100
W 1 0001C200
W 1 00021480
W 1 0000FFF0
W 1 0003F000
I
P 1 0 0 1080 44 0
P 1 0 0 10FF 48 0
P 1 0 0 1004 40 0
P 1 0 0 11FF 7C 0
P 1 0 0 1110 7F 0
P 1 0 0 12C0 2F 0
P 1 0 0 1233 24 0
P 1 0 0 13FF 0B 0
P 1 0 0 1420 FE 0
S bayer
W 1 00100020
W 1 00000040
W 1 00100120
W 1 00000080
W 1 00100220
W 1 000000C0
W 1 00100320
W 1 00000100
W 0 00000019
I
P 0 1 0 0000 00 1
P 0 0 0 0000 00 0
P 1 0 0 2011 20 0
P 1 0 0 2022 10 0
P 1 0 0 2033 20 0
P 0 0 0 0000 00 0
P 1 0 0 2044 40 0
P 1 0 0 2055 30 0
P 1 0 0 2066 40 0
P 0 0 1 0000 00 0
W 0 0000001A
I
P 0 1 0 0000 00 1
P 0 0 0 0000 00 0
P 1 0 0 2077 30 0
P 1 0 0 2088 40 0
P 0 0 0 0000 00 0
P 1 0 0 2099 10 0
P 1 0 0 20AA 20 0
P 0 0 1 0000 00 0
S gating
W 0 00000010
I
P 0 1 0 0000 00 0
P 0 0 1 0000 00 0
W 0 00000018
I
P 0 1 0 0000 00 1
P 0 0 1 0000 00 0
W 0 00000008
I
P 0 1 0 0000 00 0
P 1 0 0 0012 01 0
P 0 0 1 0000 00 0
T
I
P 0 1 0 0000 00 1
P 1 0 0 0034 01 0
P 0 0 1 0000 00 0
I
P 0 1 0 0000 00 0
P 1 0 0 0056 01 0
P 0 0 1 0000 00 0
W 0 00000028
I
P 0 1 0 0000 00 1
P 1 0 0 0078 01 0
P 0 0 1 0000 00 0
I
P 0 1 0 0000 00 0
P 0 0 1 0000 00 0
S sync
P 1 0 0 0000 01 0
P 0 0 0 0000 00 0
P 1 0 0 01FF FF 0
P 1 0 1 0280 80 0
P 0 0 0 0000 00 0
P 0 0 1 0000 00 0
P 1 0 0 0301 55 0

// File: vlog.f
logic/gamma_cfg_pkg.sv
logic/gamma_pix_pkg.sv
logic/gamma_regs.sv
logic/gamma_table_ram.sv
logic/gamma_frame_gate.sv
logic/bayer_color_tracker.sv
logic/gamma_interp.sv
logic/sens_gamma_top.sv
verif/tb_clkgen.sv
verif/sens_gamma_chk.sv
verif/sens_gamma_tb.sv

// File: Makefile
# Verilator build and run of the gamma block testbench

VERILATOR ?= verilator
TOP       ?= sens_gamma_tb
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' vlog.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): vlog.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f vlog.f

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
